// File: bench/led_panel_chk.sv
module led_panel_chk import led_panel_pkg::*; (
    input logic   clk_root,
    input logic   rst,
    input panel_t panel
);

    int fail_count = 0;  // Failure tally, read back per test

    a_latch_oe: assert property (@(posedge clk_root) disable iff (rst)
        !(panel.latch && panel.oe))
    else begin
        $error("latch and oe high in the same cycle");
        fail_count++;
    end

    // Shifting must stop while a row is lit
    a_clk_oe: assert property (@(posedge clk_root) disable iff (rst)
        !(panel.clk_pixel && panel.oe))
    else begin
        $error("clk_pixel high while oe is high");
        fail_count++;
    end

    a_row_hold: assert property (@(posedge clk_root) disable iff (rst)
        (panel.oe && $past(panel.oe)) |-> $stable(panel.row_addr))
    else begin
        $error("row_addr changed while oe is high");
        fail_count++;
    end

endmodule

bind led_panel_top led_panel_chk u_chk (.clk_root, .rst, .panel);

// File: bench/led_panel_tb.sv
`include "led_panel_defs.svh"

module led_panel_tb import led_panel_pkg::*; ();

    localparam int COLS         = `PANEL_COLS;
    localparam int FRAME_LATCH  = `SCAN_ROWS * `PLANES;
    localparam int OE_PER_ROW   = `OE_UNIT * ((1 << `PLANES) - 1);
    localparam int FRAME_CYCLES = `SCAN_ROWS * (`PLANES * (2 * COLS + 3) + OE_PER_ROW);
    localparam int NUM_WRITES   = 40;
    localparam int JUNK_ROUNDS  = 4;
    localparam int NUM_CMDS     = NUM_WRITES + 1 + 2 * JUNK_ROUNDS;
    localparam int LIMIT_CYCLES = (NUM_CMDS + 10) * FRAME_CYCLES;

    logic       clk_root = 1'b0;
    logic       rst;
    logic       uart_rx;
    panel_t     panel;
    pixel_t     model_fb [`PANEL_ROWS * COLS];
    enables_t   model_en;
    logic [2:0] cap_top [COLS];
    logic [2:0] cap_bot [COLS];
    logic [1:0] exp_row;
    logic [1:0] exp_plane;
    logic [1:0] disp_plane;
    int         cap_n, cap_start, oe_run, cycle, quiet_mark, latch_count;
    int         checked, errors, err_mark, chk_mark, asrt_mark, test_num, failed_tests;
    bit         sending;
    int         seed = 38;

    led_panel_top dut (.clk_root, .rst, .uart_rx, .panel);

    always #5 clk_root = ~clk_root;

    function automatic logic [2:0] expected_bits(pixel_t pix, logic [1:0] pl, enables_t en);
        logic [2:0] bits;
        bits = {pix.blue[pl], pix.green[pl], pix.red[pl]};
        for (int ch = 0; ch < 3; ch++) begin
            if (!en.rgb_en[ch] || !en.plane_en[pl]) bits[ch] = 1'b0;  // Blanked
        end
        return bits;
    endfunction

    task automatic check_pixel_bits(string name, int col, logic [2:0] got, logic [2:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s col %0d row %0d plane %0d got 0x%0h expected 0x%0h",
                     name, col, exp_row, exp_plane, got, exp);
            errors++;
        end
    endtask

    task automatic check_panel(string name, panel_t got, panel_t exp, panel_t mask);
        if (((got ^ exp) & mask) !== '0) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got & mask, exp & mask);
            errors++;
        end
    endtask

    task automatic check_duration(string name, int got, int exp);
        if (got != exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Only captures that began after the last command settled
    task automatic check_capture();
        int top_idx;
        if (cap_n != COLS) begin
            $display("capture for row %0d plane %0d held %0d columns instead of %0d",
                     exp_row, exp_plane, cap_n, COLS);
            errors++;
        end else if (!sending && cap_start > quiet_mark + 2) begin
            for (int c = 0; c < COLS; c++) begin
                top_idx = exp_row * COLS + c;
                check_pixel_bits("rgb_top", c, cap_top[c],
                                 expected_bits(model_fb[top_idx], exp_plane, model_en));
                check_pixel_bits("rgb_bot", c, cap_bot[c],
                                 expected_bits(model_fb[top_idx + `SCAN_ROWS * COLS],
                                               exp_plane, model_en));
            end
            checked++;
        end
    endtask

    // Panel capture, sampled mid-cycle
    always @(negedge clk_root) begin
        cycle++;
        if (rst) begin
            cap_n     = 0;
            oe_run    = 0;
            exp_row   = '0;
            exp_plane = '0;
        end else begin
            if (panel.clk_pixel) begin
                if (cap_n == 0) cap_start = cycle;
                if (cap_n < COLS) begin
                    cap_top[cap_n] = panel.rgb_top;
                    cap_bot[cap_n] = panel.rgb_bot;
                end
                cap_n++;
            end
            if (panel.latch) begin
                check_panel("row_addr", panel, '{row_addr: exp_row, default: '0},
                            '{row_addr: 2'b11, default: '0});
                check_capture();
                cap_n      = 0;
                disp_plane = exp_plane;
                latch_count++;
                if (exp_plane == 2'(`PLANES - 1)) exp_row = exp_row + 2'd1;
                exp_plane = exp_plane + 2'd1;  // Wraps with the row step
            end
            if (panel.oe) begin
                oe_run++;
            end else if (oe_run != 0) begin
                check_duration("oe_high_cycles", oe_run, `OE_UNIT * (2 ** disp_plane));
                oe_run = 0;
            end
        end
    end

    task automatic send_cmd(logic [31:0] bytes, int n);
        logic [9:0] frame;
        sending = 1'b1;
        for (int k = n - 1; k >= 0; k--) begin
            frame = {1'b1, bytes[8*k +: 8], 1'b0};  // Stop, data, start
            for (int i = 0; i < 10; i++) begin
                uart_rx = frame[i];
                repeat (`UART_TICKS) @(negedge clk_root);
            end
        end
        repeat (4) @(negedge clk_root);
        quiet_mark = cycle;
        sending    = 1'b0;
    endtask

    task automatic wait_latches(int n);
        int target;
        target = latch_count + n;
        wait (latch_count >= target);
    endtask

    task automatic start_test();
        test_num++;
        err_mark  = errors;
        chk_mark  = checked;
        asrt_mark = dut.u_chk.fail_count;
    endtask

    task automatic end_test(string name);
        int asrt;
        asrt = dut.u_chk.fail_count - asrt_mark;
        if (asrt != 0) begin
            $display("%0d panel assertion failures during test %0d", asrt, test_num);
            errors += asrt;
        end
        if (checked == chk_mark) begin
            $display("no capture was checked during test %0d", test_num);
            errors++;
        end
        if (errors == err_mark) begin
            $display("test %0d %s: ok, %0d captures", test_num, name, checked - chk_mark);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
            failed_tests++;
        end
    endtask

    initial begin
        logic [7:0] addr, hi, lo, en_byte, junk;
        uart_rx  = 1'b1;
        rst      = 1'b1;
        model_en = '1;
        for (int i = 0; i < `PANEL_ROWS * COLS; i++) model_fb[i] = '0;

        start_test();
        repeat (10) begin
            @(negedge clk_root);
            check_panel("reset pins", panel, '0,
                        '{clk_pixel: 1'b1, latch: 1'b1, oe: 1'b1, default: '0});
        end
        rst = 1'b0;
        wait_latches(FRAME_LATCH);
        end_test("blank frame after reset");

        start_test();
        repeat (NUM_WRITES) begin
            addr = 8'($random(seed));
            hi   = 8'($random(seed));
            lo   = 8'($random(seed));
            model_fb[addr[6:0]] = '{red: hi[3:0], green: lo[7:4], blue: lo[3:0]};
            send_cmd({"W", addr, hi, lo}, 4);
        end
        wait_latches(2 * FRAME_LATCH);
        end_test("random pixel writes");

        // Order and oe widths are checked by the capture process
        start_test();
        wait_latches(FRAME_LATCH);
        end_test("scan order and plane weighting");

        start_test();
        en_byte  = 8'($random(seed));
        model_en = '{rgb_en: en_byte[6:4], plane_en: en_byte[3:0]};
        send_cmd({16'h0, "E", en_byte}, 2);
        wait_latches(2 * FRAME_LATCH);
        end_test("channel and plane enables");

        start_test();
        repeat (JUNK_ROUNDS) begin
            do begin
                junk = 8'($random(seed));
            end while (junk == "W" || junk == "E");
            send_cmd({24'h0, junk}, 1);
            addr = 8'($random(seed));
            hi   = 8'($random(seed));
            lo   = 8'($random(seed));
            model_fb[addr[6:0]] = '{red: hi[3:0], green: lo[7:4], blue: lo[3:0]};
            send_cmd({"W", addr, hi, lo}, 4);
        end
        wait_latches(2 * FRAME_LATCH);
        end_test("stray bytes ignored");

        $display("%0d tests, %0d failed, %0d errors, %0d captures checked",
                 test_num, failed_tests, errors, checked);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from command count and frame length
    initial begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: include/led_panel_defs.svh
`ifndef LED_PANEL_DEFS_SVH
`define LED_PANEL_DEFS_SVH

// Panel geometry, two halves scanned together
`define PANEL_COLS 16
`define PANEL_ROWS 8
`define SCAN_ROWS  4

// Bits per colour channel
`define PLANES 4

// clk_root cycles per serial bit, small for simulation
`define UART_TICKS 8

// Display cycles of plane 0, doubled per plane
`define OE_UNIT 4

`endif

// File: led_panel.f
+incdir+include
rtl/led_panel_pkg.sv
rtl/uart_byte_rx.sv
rtl/frame_loader.sv
rtl/frame_ram.sv
rtl/scan_timer.sv
rtl/scan_sequencer.sv
rtl/pixel_fetch.sv
rtl/led_panel_top.sv
bench/led_panel_chk.sv
bench/led_panel_tb.sv

// File: rtl/frame_loader.sv
module frame_loader import led_panel_pkg::*; (
    input  logic       clk_root,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_strobe,
    output ram_wr_t    ram_wr,
    output enables_t   enables
);

    cmd_state_t state;
    logic       wr_en;
    pix_addr_t  wr_addr;
    pixel_t     wr_pix;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state   <= IDLE;
            wr_en   <= 1'b0;
            enables <= '1;  // Everything shown until told otherwise
        end else begin
            wr_en <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    IDLE: begin
                        if (rx_data == "W") begin
                            state <= ADDR;
                        end else if (rx_data == "E") begin
                            state <= ENABLE;
                        end
                    end
                    ADDR: state <= HIGH;
                    HIGH: state <= LOW;
                    LOW: begin
                        state <= IDLE;
                        wr_en <= 1'b1;  // Single-cycle write after the last byte
                    end
                    ENABLE: begin
                        state   <= IDLE;
                        enables <= '{rgb_en: rx_data[6:4], plane_en: rx_data[3:0]};
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Pixel assembled as the bytes arrive
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            case (state)
                ADDR: wr_addr <= rx_data[6:0];
                HIGH: wr_pix.red <= rx_data[3:0];
                LOW: begin
                    wr_pix.green <= rx_data[7:4];
                    wr_pix.blue  <= rx_data[3:0];
                end
                default: ;
            endcase
        end
    end

    assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_pix};

endmodule

// File: rtl/frame_ram.sv
`include "led_panel_defs.svh"

module frame_ram import led_panel_pkg::*; (
    input  logic      clk_root,
    input  ram_wr_t   ram_wr,
    input  pix_addr_t rd_addr,
    output pixel_t    rd_data
);

    localparam int DEPTH = `PANEL_ROWS * `PANEL_COLS;

    pixel_t mem [DEPTH];

    // Blank frame at power-up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Port A, loader writes
    always_ff @(posedge clk_root) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // Port B, scan reads, old data on a same-cycle collision
    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/led_panel_pkg.sv
package led_panel_pkg;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    typedef struct packed {
        logic [2:0] row;  // 0..3 top half, 4..7 bottom half
        logic [3:0] col;
    } pix_addr_t;

    typedef struct packed {
        logic [1:0] row;  // Scan row, drives both halves
        logic [3:0] col;
        logic [1:0] plane;
    } scan_pos_t;

    typedef struct packed {
        logic [2:0] rgb_en;    // Bit 0 red, 1 green, 2 blue
        logic [3:0] plane_en;
    } enables_t;

    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        pixel_t    data;
    } ram_wr_t;

    typedef struct packed {
        logic [2:0] rgb_top;  // Same channel order as rgb_en
        logic [2:0] rgb_bot;
        logic       clk_pixel;
        logic       latch;
        logic       oe;       // Active high here, panel pin is usually inverted
        logic [1:0] row_addr;
    } panel_t;

    typedef enum logic [2:0] {IDLE, ADDR, HIGH, LOW, ENABLE} cmd_state_t;

    typedef enum logic [1:0] {SHIFT, DRAIN, LATCH, DISPLAY} scan_state_t;

endpackage

// File: rtl/led_panel_top.sv
module led_panel_top import led_panel_pkg::*; (
    input  logic   clk_root,
    input  logic   rst,
    input  logic   uart_rx,
    output panel_t panel
);

    logic [7:0] rx_data;
    logic       rx_strobe;
    ram_wr_t    ram_wr;
    enables_t   enables;
    pix_addr_t  rd_addr;
    pixel_t     rd_data;
    scan_pos_t  scan_pos;
    logic       fetch_valid;
    logic       col_start;
    logic       disp_start;
    logic [3:0] column;
    logic       col_done;
    logic       disp_done;
    logic       latch;
    logic       oe;
    logic [1:0] row_addr;
    logic [2:0] rgb_top;
    logic [2:0] rgb_bot;
    logic       clk_pixel;

    uart_byte_rx u_rx (.clk_root, .rst, .uart_rx, .rx_data, .rx_strobe);

    frame_loader u_loader (.clk_root, .rst, .rx_data, .rx_strobe, .ram_wr, .enables);

    frame_ram u_ram (.clk_root, .ram_wr, .rd_addr, .rd_data);

    scan_timer u_timer (
        .clk_root, .rst, .col_start, .disp_start, .plane(scan_pos.plane),
        .column, .col_done, .disp_done
    );

    scan_sequencer u_seq (
        .clk_root, .rst, .column, .col_done, .disp_done, .scan_pos, .fetch_valid,
        .col_start, .disp_start, .latch, .oe, .row_addr
    );

    pixel_fetch u_fetch (
        .clk_root, .rst, .scan_pos, .fetch_valid, .enables, .rd_addr, .rd_data,
        .rgb_top, .rgb_bot, .clk_pixel
    );

    assign panel = '{rgb_top: rgb_top, rgb_bot: rgb_bot, clk_pixel: clk_pixel,
                     latch: latch, oe: oe, row_addr: row_addr};

endmodule

// File: rtl/pixel_fetch.sv
`include "led_panel_defs.svh"

module pixel_fetch import led_panel_pkg::*; (
    input  logic       clk_root,
    input  logic       rst,
    input  scan_pos_t  scan_pos,
    input  logic       fetch_valid,
    input  enables_t   enables,
    output pix_addr_t  rd_addr,
    input  pixel_t     rd_data,
    output logic [2:0] rgb_top,
    output logic [2:0] rgb_bot,
    output logic       clk_pixel
);

    logic       s1_valid;  // Top read issued, bottom read goes out now
    scan_pos_t  s1_pos;
    logic       s2_valid;  // Bottom word on rd_data
    logic [1:0] s2_plane;
    pixel_t     top_hold;

    function automatic logic [2:0] plane_bits(pixel_t pix, logic [1:0] pl, enables_t en);
        logic on;
        on = en.plane_en[pl];
        return {pix.blue[pl], pix.green[pl], pix.red[pl]} & en.rgb_en & {3{on}};
    endfunction

    // Bottom read has priority, fetches never land on back-to-back cycles
    always_comb begin
        if (s1_valid) begin
            rd_addr.row = 3'({1'b0, s1_pos.row} + `SCAN_ROWS);
            rd_addr.col = s1_pos.col;
        end else begin
            rd_addr.row = {1'b0, scan_pos.row};
            rd_addr.col = scan_pos.col;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= fetch_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_root) begin
        s1_pos   <= scan_pos;
        s2_plane <= s1_pos.plane;
        if (s1_valid) top_hold <= rd_data;  // Keep top until bottom arrives
    end

    assign rgb_top   = plane_bits(top_hold, s2_plane, enables);
    assign rgb_bot   = plane_bits(rd_data, s2_plane, enables);
    assign clk_pixel = s2_valid;

endmodule

// File: rtl/scan_sequencer.sv
`include "led_panel_defs.svh"

module scan_sequencer import led_panel_pkg::*; (
    input  logic       clk_root,
    input  logic       rst,
    input  logic [3:0] column,
    input  logic       col_done,
    input  logic       disp_done,
    output scan_pos_t  scan_pos,
    output logic       fetch_valid,
    output logic       col_start,
    output logic       disp_start,
    output logic       latch,
    output logic       oe,
    output logic [1:0] row_addr
);

    scan_state_t state;
    logic [1:0]  row;
    logic [1:0]  plane;
    logic        pix_phase;  // Fetch on even cycles, fetch path reads twice per column
    logic        drain_cnt;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state      <= SHIFT;
            row        <= '0;
            plane      <= '0;
            pix_phase  <= 1'b0;
            drain_cnt  <= 1'b0;
            col_start  <= 1'b1;  // First SHIFT right out of reset
            disp_start <= 1'b0;
            row_addr   <= '0;
        end else begin
            col_start  <= 1'b0;
            disp_start <= 1'b0;
            case (state)
                SHIFT: begin
                    pix_phase <= ~pix_phase;  // Even cycle count, ends back at 0
                    if (col_done) state <= DRAIN;
                end
                DRAIN: begin
                    drain_cnt <= ~drain_cnt;
                    if (drain_cnt) begin
                        state    <= LATCH;
                        row_addr <= row;  // Row shown is the row just shifted
                    end
                end
                LATCH: begin
                    state      <= DISPLAY;
                    disp_start <= 1'b1;
                end
                DISPLAY: begin
                    if (disp_done) begin
                        state     <= SHIFT;
                        col_start <= 1'b1;
                        plane     <= plane + 1'b1;
                        if (plane == 2'(`PLANES - 1)) begin
                            plane <= '0;
                            row   <= (row == 2'(`SCAN_ROWS - 1)) ? 2'd0 : row + 1'b1;
                        end
                    end
                end
                default: state <= SHIFT;
            endcase
        end
    end

    assign scan_pos    = '{row: row, col: column, plane: plane};
    assign fetch_valid = (state == SHIFT) && !pix_phase;
    assign latch       = (state == LATCH);
    assign oe          = (state == DISPLAY);

endmodule

// File: rtl/scan_timer.sv
`include "led_panel_defs.svh"

module scan_timer import led_panel_pkg::*; (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       col_start,
    input  logic       disp_start,
    input  logic [1:0] plane,
    output logic [3:0] column,
    output logic       col_done,
    output logic       disp_done
);

    // Two cycles per column, pixel clock low then high
    localparam int COL_W  = $clog2(`PANEL_COLS) + 1;
    localparam int DISP_W = $clog2((`OE_UNIT << (`PLANES - 1)) + 1);

    logic [COL_W-1:0]  col_cnt;
    logic              col_run;
    logic              col_active;
    logic [DISP_W-1:0] disp_cnt;
    logic [DISP_W-1:0] disp_left;
    logic              disp_run;
    logic              disp_active;

    assign col_active = col_start | col_run;  // Counting starts in the start cycle
    assign column     = col_cnt[COL_W-1:1];
    assign col_done   = col_active && (col_cnt == COL_W'(2 * `PANEL_COLS - 1));

    // Cycles left including the current one
    assign disp_left   = disp_start ? (DISP_W'(`OE_UNIT) << plane) : disp_cnt;
    assign disp_active = disp_start | disp_run;
    assign disp_done   = disp_active && (disp_left == DISP_W'(1));

    always_ff @(posedge clk_root) begin
        if (rst) begin
            col_cnt  <= '0;
            col_run  <= 1'b0;
            disp_cnt <= '0;
            disp_run <= 1'b0;
        end else begin
            if (col_active) begin
                col_cnt <= col_cnt + 1'b1;  // Wraps back to 0 after the last column
                col_run <= !col_done;
            end
            if (disp_active) begin
                disp_cnt <= disp_left - 1'b1;
                disp_run <= !disp_done;
            end
        end
    end

endmodule

// File: rtl/uart_byte_rx.sv
`include "led_panel_defs.svh"

module uart_byte_rx import led_panel_pkg::*; (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       uart_rx,
    output logic [7:0] rx_data,
    output logic       rx_strobe
);

    localparam int TICK_W = $clog2(`UART_TICKS + 1);

    logic [1:0]        rx_sync;   // Two-flop synchronizer
    logic              rx_prev;
    logic              busy;
    logic [TICK_W-1:0] tick_cnt;
    logic [3:0]        bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [7:0]        shift_q;
    logic              sample;

    assign sample = busy && (tick_cnt == '0);

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rx_sync   <= 2'b11;  // Line idles high
            rx_prev   <= 1'b1;
            busy      <= 1'b0;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_sync   <= {rx_sync[0], uart_rx};
            rx_prev   <= rx_sync[1];
            rx_strobe <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync[1]) begin  // Falling start edge
                    busy     <= 1'b1;
                    tick_cnt <= TICK_W'(`UART_TICKS / 2 - 1);  // Half bit to mid-start
                    bit_idx  <= '0;
                end
            end else if (!sample) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else begin
                tick_cnt <= TICK_W'(`UART_TICKS - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync[1]) begin
                    busy <= 1'b0;  // Glitch, not a real start bit
                end else if (bit_idx == 4'd9) begin
                    busy      <= 1'b0;
                    rx_strobe <= rx_sync[1];  // Bad stop bit drops the byte
                end
            end
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk_root) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift_q <= {rx_sync[1], shift_q[7:1]};
        end
        if (sample && bit_idx == 4'd9) begin
            rx_data <= shift_q;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module led_panel_tb -f led_panel.f
./obj_dir/Vled_panel_tb +verilator+error+limit+1000 | tee sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    echo "run ok"
else
    echo "run failed, see sim.log"
    exit 1
fi
